// File: source/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    // One received PS/2 byte with its strobe.
    typedef struct packed {
        logic [7:0] code;
        logic       valid;
    } scan_t;

    // Key controller states.
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        PREFIX_E0 = 2'd1,
        BREAK     = 2'd2,
        LOAD      = 2'd3
    } key_state_e;

    localparam logic [7:0] CODE_BREAK = 8'hF0; // Release prefix.
    localparam logic [7:0] CODE_EXT   = 8'hE0; // Extended key prefix.

endpackage

`default_nettype wire

// File: source/ps2_frame_rx.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_frame_rx
    import kbd_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ps2_clk,
    input  logic  ps2_dat,
    input  logic  expired,
    output logic  fall_edge,
    output logic  frame_busy,
    output scan_t rx_byte
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_prev;
    logic                   clk_s;
    logic                   dat_s;
    logic [3:0]             bit_cnt;
    logic [9:0]             shift;
    logic [10:0]            frame_next;
    logic                   frame_ok;
    logic [7:0]             code_q;
    logic                   valid_q;

    assign clk_s = clk_sync[SYNC_STAGES-1];
    assign dat_s = dat_sync[SYNC_STAGES-1];

    assign fall_edge = clk_prev & ~clk_s;

    // Frame as it stands once the current sample is taken, start bit in bit 0.
    assign frame_next = {dat_s, shift};

    // Start low, odd parity over data plus parity, stop high.
    assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

    assign rx_byte.code  = code_q;
    assign rx_byte.valid = valid_q;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1; // Lines idle high.
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync[0] <= ps2_clk;
            dat_sync[0] <= ps2_dat;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                clk_sync[i] <= clk_sync[i-1];
                dat_sync[i] <= dat_sync[i-1];
            end
            clk_prev <= clk_s;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            frame_busy <= 1'b0;
            bit_cnt    <= 4'd0;
            valid_q    <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            if (expired)
            begin
                frame_busy <= 1'b0; // Drop the partial frame.
                bit_cnt    <= 4'd0;
            end
            else if (fall_edge)
            begin
                if (bit_cnt == 4'd10)
                begin
                    frame_busy <= 1'b0;
                    bit_cnt    <= 4'd0;
                    valid_q    <= frame_ok;
                end
                else if (bit_cnt == 4'd0 && dat_s)
                begin
                    frame_busy <= 1'b0; // No start bit, keep waiting.
                end
                else
                begin
                    frame_busy <= 1'b1;
                    bit_cnt    <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall_edge)
        begin
            shift <= frame_next[10:1];
            if (bit_cnt == 4'd10)
                code_q <= frame_next[8:1];
        end
    end

endmodule

`default_nettype wire

// File: source/frame_timer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_timer
#(
    parameter int TIMEOUT_CYCLES = 2000
)
(
    input  logic clk,
    input  logic rst,
    input  logic frame_busy,
    input  logic fall_edge,
    output logic expired
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            count   <= '0;
            expired <= 1'b0;
        end
        else if (fall_edge || !frame_busy)
        begin
            count   <= '0; // Line is alive or no frame in progress.
            expired <= 1'b0;
        end
        else
        begin
            expired <= (count == CNT_W'(TIMEOUT_CYCLES - 1));
            if (count != CNT_W'(TIMEOUT_CYCLES))
                count <= count + CNT_W'(1); // Saturates, so only one pulse.
        end
    end

endmodule

`default_nettype wire

// File: source/key_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module key_ctrl_fsm
    import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  scan_t      rx_byte,
    output logic       load,
    output logic [7:0] load_code
);

    key_state_e state;
    key_state_e state_next;
    logic       release_flag;
    logic       is_ext;
    logic       is_break;
    logic [7:0] code_q;

    assign is_ext   = rx_byte.valid && (rx_byte.code == CODE_EXT);
    assign is_break = rx_byte.valid && (rx_byte.code == CODE_BREAK);

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE, LOAD:
            begin
                state_next = IDLE;
                if (is_ext)
                    state_next = PREFIX_E0;
                else if (is_break)
                    state_next = BREAK;
            end
            PREFIX_E0:
            begin
                if (is_ext)
                    state_next = PREFIX_E0;
                else if (is_break)
                    state_next = BREAK;
                else if (rx_byte.valid)
                    state_next = release_flag ? LOAD : IDLE; // Break held over E0.
            end
            BREAK:
            begin
                if (is_ext)
                    state_next = PREFIX_E0;
                else if (is_break)
                    state_next = BREAK;
                else if (rx_byte.valid)
                    state_next = LOAD;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state        <= IDLE;
            release_flag <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (is_break)
                release_flag <= 1'b1;
            else if (rx_byte.valid && !is_ext)
                release_flag <= 1'b0; // Plain code consumes the pending break.
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_byte.valid)
            code_q <= rx_byte.code;
    end

    assign load      = (state == LOAD);
    assign load_code = code_q;

endmodule

`default_nettype wire

// File: source/hex_display.sv
`timescale 1ns/100ps
`default_nettype none

module hex_display
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] load_code,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    logic [7:0] key_reg;
    logic [7:0] key_next;

    // Active-low segments, bit 6 is g and bit 0 is a.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_to_seg = 7'h40;
            4'h1: hex_to_seg = 7'h79;
            4'h2: hex_to_seg = 7'h24;
            4'h3: hex_to_seg = 7'h30;
            4'h4: hex_to_seg = 7'h19;
            4'h5: hex_to_seg = 7'h12;
            4'h6: hex_to_seg = 7'h02;
            4'h7: hex_to_seg = 7'h78;
            4'h8: hex_to_seg = 7'h00;
            4'h9: hex_to_seg = 7'h10;
            4'hA: hex_to_seg = 7'h08;
            4'hB: hex_to_seg = 7'h03;
            4'hC: hex_to_seg = 7'h46;
            4'hD: hex_to_seg = 7'h21;
            4'hE: hex_to_seg = 7'h06;
            default: hex_to_seg = 7'h0E;
        endcase
    endfunction

    // Decode the value the register is about to hold, for one cycle of latency.
    assign key_next = load ? load_code : key_reg;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_reg <= 8'h00;
            seg_lo  <= {1'b1, hex_to_seg(4'h0)};
            seg_hi  <= {1'b1, hex_to_seg(4'h0)};
        end
        else
        begin
            key_reg <= key_next;
            seg_lo  <= {1'b1, hex_to_seg(key_next[3:0])}; // Decimal point off.
            seg_hi  <= {1'b1, hex_to_seg(key_next[7:4])};
        end
    end

endmodule

`default_nettype wire

// File: source/kbd_top.sv
`timescale 1ns/100ps
`default_nettype none

module kbd_top
    import kbd_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 2000,
    parameter int SYNC_STAGES    = 2
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    scan_t      rx_byte;
    logic       fall_edge;
    logic       frame_busy;
    logic       expired;
    logic       load;
    logic [7:0] load_code;

    ps2_frame_rx #(
        .SYNC_STAGES(SYNC_STAGES)
    ) rx0 (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .expired   (expired),
        .fall_edge (fall_edge),
        .frame_busy(frame_busy),
        .rx_byte   (rx_byte)
    );

    frame_timer #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) timer0 (
        .clk       (clk),
        .rst       (rst),
        .frame_busy(frame_busy),
        .fall_edge (fall_edge),
        .expired   (expired)
    );

    key_ctrl_fsm ctrl0 (
        .clk      (clk),
        .rst      (rst),
        .rx_byte  (rx_byte),
        .load     (load),
        .load_code(load_code)
    );

    hex_display disp0 (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .load_code(load_code),
        .seg_lo   (seg_lo),
        .seg_hi   (seg_hi)
    );

endmodule

`default_nettype wire

// File: verif/tb_kbd_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_kbd_top
    import kbd_pkg::*;
();

    localparam int HALF_PS2   = 40;
    localparam int N_FRAMES   = 52;
    localparam int MAX_CYCLES = N_FRAMES * 11 * 80 * 12 / 10;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [7:0]  seg_lo;
    logic [7:0]  seg_hi;

    logic [31:0] lcg_state;
    logic [7:0]  exp_code;
    logic        exp_release;
    logic        sending;
    logic [7:0]  idle_cnt = 8'd0;
    logic        check_en;
    logic [7:0]  exp_lo;
    logic [7:0]  exp_hi;
    int          cycle_cnt = 0;

    kbd_top #(
        .TIMEOUT_CYCLES(200)
    ) dut0 (
        .clk    (clk),
        .rst    (rst),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat),
        .seg_lo (seg_lo),
        .seg_hi (seg_hi)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Segments gfedcba, active high.
    function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: seg_pattern = 7'h3F;
            4'h1: seg_pattern = 7'h06;
            4'h2: seg_pattern = 7'h5B;
            4'h3: seg_pattern = 7'h4F;
            4'h4: seg_pattern = 7'h66;
            4'h5: seg_pattern = 7'h6D;
            4'h6: seg_pattern = 7'h7D;
            4'h7: seg_pattern = 7'h07;
            4'h8: seg_pattern = 7'h7F;
            4'h9: seg_pattern = 7'h6F;
            4'hA: seg_pattern = 7'h77;
            4'hB: seg_pattern = 7'h7C;
            4'hC: seg_pattern = 7'h39;
            4'hD: seg_pattern = 7'h5E;
            4'hE: seg_pattern = 7'h79;
            default: seg_pattern = 7'h71;
        endcase
    endfunction

    assign exp_lo = {1'b1, ~seg_pattern(exp_code[3:0])}; // Pins are active low.
    assign exp_hi = {1'b1, ~seg_pattern(exp_code[7:4])};

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Never returns a prefix byte.
    function automatic logic [7:0] random_code();
        logic [7:0] c;
        lcg_state = lcg_next(lcg_state);
        c = lcg_state[23:16];
        if (c == CODE_BREAK || c == CODE_EXT)
            c = c ^ 8'h01;
        random_code = c;
    endfunction

    // Random code other than the one on display.
    function automatic logic [7:0] fresh_code();
        logic [7:0] c;
        c = random_code();
        while (c == exp_code)
            c = random_code();
        fresh_code = c;
    endfunction

    // Expected behavior of the byte stream.
    task automatic model_byte(input logic [7:0] code);
        if (code == CODE_BREAK)
            exp_release = 1'b1;
        else if (code != CODE_EXT)
        begin
            if (exp_release)
                exp_code = code;
            exp_release = 1'b0;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] code, input logic bad_parity, input int n_bits);
        logic [10:0] frame;
        frame = {1'b1, ~^code ^ bad_parity, code, 1'b0}; // Stop, parity, data, start.
        sending = 1'b1;
        for (int i = 0; i < n_bits; i++)
        begin
            ps2_dat = frame[0];
            frame = frame >> 1;
            wait_cycles(HALF_PS2);
            ps2_clk = 1'b0;
            wait_cycles(HALF_PS2);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        if (n_bits == 11 && !bad_parity)
            model_byte(code);
        sending = 1'b0;
    endtask

    task automatic settle();
        wait_cycles(25);
    endtask

    always @(posedge clk)
    begin
        if (!rst || sending)
            idle_cnt <= 8'd0;
        else if (idle_cnt != 8'hFF)
            idle_cnt <= idle_cnt + 8'd1;
    end

    assign check_en = (idle_cnt >= 8'd20); // Display has long settled.

    lo_matches: assert property (@(posedge clk) check_en |-> seg_lo == exp_lo)
    else
    begin
        $display("Error: seg_lo = 0x%02h, expected 0x%02h (code 0x%02h, state %s)",
                 $sampled(seg_lo), exp_lo, exp_code, dut0.ctrl0.state.name());
        $display("Test failures found");
        $fatal(1, "Low digit shows the wrong pattern");
    end

    hi_matches: assert property (@(posedge clk) check_en |-> seg_hi == exp_hi)
    else
    begin
        $display("Error: seg_hi = 0x%02h, expected 0x%02h (code 0x%02h, state %s)",
                 $sampled(seg_hi), exp_hi, exp_code, dut0.ctrl0.state.name());
        $display("Test failures found");
        $fatal(1, "High digit shows the wrong pattern");
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("The run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "Timed out");
        end
    end

    initial
    begin
        logic [7:0] code;
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        sending     = 1'b0;
        lcg_state   = 32'h62ff7368;
        exp_code    = 8'h00;
        exp_release = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        settle(); // Both digits read 0.

        repeat (20)
        begin
            code = fresh_code();
            send_frame(CODE_BREAK, 1'b0, 11);
            send_frame(code, 1'b0, 11);
            settle();
        end

        send_frame(fresh_code(), 1'b0, 11); // Make code only.
        settle();

        send_frame(CODE_EXT, 1'b0, 11);
        send_frame(CODE_BREAK, 1'b0, 11);
        send_frame(fresh_code(), 1'b0, 11);
        settle();
        send_frame(CODE_BREAK, 1'b0, 11);
        send_frame(CODE_EXT, 1'b0, 11);
        send_frame(fresh_code(), 1'b0, 11);
        settle();

        send_frame(CODE_BREAK, 1'b1, 11); // Bad parity.
        send_frame(fresh_code(), 1'b0, 11);
        settle();

        send_frame(random_code(), 1'b0, 5);
        wait_cycles(300); // Longer than the frame timeout.
        send_frame(CODE_BREAK, 1'b0, 11);
        send_frame(fresh_code(), 1'b0, 11);
        settle();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/kbd_pkg.sv
source/ps2_frame_rx.sv
source/frame_timer.sv
source/key_ctrl_fsm.sv
source/hex_display.sv
source/kbd_top.sv
verif/tb_kbd_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the keyboard decoder testbench with Verilator and runs it.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_kbd_top \
        -f sources.f -o sim_kbd \
    && ./obj_dir/sim_kbd \
    || { echo "Simulation did not pass"; exit 1; }
